/* files.f */
source/emesh_pkg.sv
source/emesh_fifo.sv
source/emem_core.sv
source/emem_response.sv
source/emem_top.sv
test/tb_clock.sv
test/emem_assert.sv
test/tb_emem.sv

/* run.sh */
#!/usr/bin/env bash
# Build and run the emem testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

TOP=tb_emem
LOG=sim.log

verilator --binary --timing --assert \
   --top-module "$TOP" \
   --Mdir obj_dir \
   -f files.f

./obj_dir/V"$TOP" | tee "$LOG"

if grep -q "ALL CHECKS PASSED" "$LOG"; then
   echo "Simulation passed"
else
   echo "Simulation failed, see $LOG"
   exit 1
fi

/* source/emem_core.sv */
`timescale 1ns/1ps

module emem_core #(
   parameter int MEM_LINES = 256
) (
   input  logic                     clk,
   input  logic                     arst_n,
   input  logic                     wr_valid,
   input  emesh_pkg::emesh_packet_t wr_packet,
   input  logic                     rd_valid,
   input  emesh_pkg::emesh_packet_t rd_packet,
   input  logic                     stall,
   output logic                     wr_pop,
   output logic                     rd_pop,
   output logic                     rd_req_valid,
   output emesh_pkg::mem_req_t      rd_req,
   output logic [63:0]              rd_data
);

   import emesh_pkg::*;

   localparam int IDX_W = (MEM_LINES > 1) ? $clog2(MEM_LINES) : 1;

   logic [63:0]      mem [MEM_LINES];    // 64-bit line array
   emesh_packet_t    sel_packet;         // Arbitration winner
   mem_req_t         req;                // Decoded winner
   logic             req_fire;           // Some queue popped this cycle
   logic             mem_we;
   logic             mem_re;
   logic [IDX_W-1:0] idx;                // Array index

   //############################################################
   // Arbitration, writes first
   //############################################################
   assign wr_pop = wr_valid;                       // Writes drain whenever present
   assign rd_pop = rd_valid & ~wr_valid & ~stall;  // Reads wait for writes and response room

   assign req_fire   = wr_pop | rd_pop;
   assign sel_packet = wr_valid ? wr_packet : rd_packet;

   //############################################################
   // Request decode
   //############################################################
   always_comb begin
      req.write       = sel_packet.wr_view.write;
      req.datamode    = sel_packet.wr_view.datamode;
      req.ctrlmode    = sel_packet.wr_view.ctrlmode;
      req.line        = sel_packet.wr_view.dstaddr[AW-1:3];
      req.half        = sel_packet.wr_view.dstaddr[2];
      req.return_addr = sel_packet.rd_view.return_addr;  // High word as read destination
      if (sel_packet.wr_view.datamode == dm_double) begin
         req.wdata = {sel_packet.wr_view.data_hi, sel_packet.wr_view.data_lo};
      end else begin
         // Word placed in both halves, mask picks one
         req.wdata = {sel_packet.wr_view.data_lo, sel_packet.wr_view.data_lo};
      end
   end

   assign idx    = req.line[IDX_W-1:0];      // Upper line bits alias
   assign mem_we = req_fire & req.write;
   assign mem_re = req_fire & ~req.write;

   //############################################################
   // Memory array
   //############################################################
   always_ff @(posedge clk) begin
      if (mem_we) begin
         if (req.datamode == dm_double) begin
            mem[idx] <= req.wdata;                  // Full line
         end else if (req.half) begin
            mem[idx][63:32] <= req.wdata[63:32];    // Upper half, addr bit 2 set
         end else begin
            mem[idx][31:0] <= req.wdata[31:0];      // Lower half
         end
      end
   end

   //############################################################
   // Registered read stage
   //############################################################
   always_ff @(posedge clk) begin
      if (mem_re) begin
         rd_data <= mem[idx];     // Held until the next read pop
         rd_req  <= req;          // Fields for response build
      end
   end

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         rd_req_valid <= 1'b0;
      end else begin
         rd_req_valid <= mem_re;  // One-cycle strobe per read
      end
   end

endmodule

/* source/emem_response.sv */
`timescale 1ns/1ps

module emem_response (
   input  logic                     clk,
   input  logic                     arst_n,
   input  logic                     rd_req_valid,
   input  emesh_pkg::mem_req_t      rd_req,
   input  logic [63:0]              rd_data,
   input  logic                     wait_in,
   output logic                     stall,
   output logic                     access_out,
   output emesh_pkg::emesh_packet_t packet_out
);

   import emesh_pkg::*;

   logic          pending;      // Response still waiting for delivery
   logic [DW-1:0] sel_half;     // Word picked by addr bit 2

   //############################################################
   // Hold under wait_in
   //############################################################
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         pending <= 1'b0;
      end else begin
         pending <= access_out & wait_in;   // Not taken, keep presenting
      end
   end

   // New response or one left over
   assign access_out = rd_req_valid | pending;

   // Blocks read pops so the core's read registers stay put
   assign stall = access_out & wait_in;

   //############################################################
   // Response packet build
   //############################################################
   assign sel_half = rd_req.half ? rd_data[63:32] : rd_data[31:0];

   always_comb begin
      packet_out                  = '0;
      packet_out.wr_view.write    = 1'b1;                // Answer travels as a write
      packet_out.wr_view.datamode = rd_req.datamode;
      packet_out.wr_view.ctrlmode = rd_req.ctrlmode;     // Echo
      packet_out.wr_view.dstaddr  = rd_req.return_addr;
      if (rd_req.datamode == dm_double) begin
         packet_out.wr_view.data_lo = rd_data[31:0];
         packet_out.wr_view.data_hi = rd_data[63:32];
      end else begin
         packet_out.wr_view.data_lo = sel_half;          // High word left zero
      end
   end

endmodule

/* source/emem_top.sv */
`timescale 1ns/1ps

module emem_top #(
   parameter int FIFO_DEPTH = 4,
   parameter int MEM_LINES  = 256
) (
   input  logic                     clk,
   input  logic                     arst_n,
   input  logic                     access_in,
   input  emesh_pkg::emesh_packet_t packet_in,
   output logic                     wait_out,
   output logic                     access_out,
   output emesh_pkg::emesh_packet_t packet_out,
   input  logic                     wait_in
);

   import emesh_pkg::*;

   logic          accept;         // Packet taken this edge
   logic          wr_push;
   logic          rd_push;
   logic          wr_full;
   logic          rd_full;
   logic          wr_nonempty;
   logic          rd_nonempty;
   logic          wr_pop;
   logic          rd_pop;
   emesh_packet_t wr_head;
   emesh_packet_t rd_head;
   logic          rd_req_valid;
   mem_req_t      rd_req;
   logic [63:0]   rd_data;
   logic          stall;          // Response stage holding

   //############################################################
   // Entry steering
   //############################################################
   assign wait_out = wr_full | rd_full;                       // Either queue full
   assign accept   = access_in & ~wait_out;
   assign wr_push  = accept & packet_in.wr_view.write;        // Writes
   assign rd_push  = accept & ~packet_in.wr_view.write;       // Reads

   //############################################################
   // Queue stage
   //############################################################
   emesh_fifo #(
      .FIFO_DEPTH (FIFO_DEPTH)
   ) wr_fifo (
      .clk         (clk),
      .arst_n      (arst_n),
      .push        (wr_push),
      .push_packet (packet_in),
      .pop         (wr_pop),
      .head_packet (wr_head),
      .nonempty    (wr_nonempty),
      .full        (wr_full)
   );

   emesh_fifo #(
      .FIFO_DEPTH (FIFO_DEPTH)
   ) rd_fifo (
      .clk         (clk),
      .arst_n      (arst_n),
      .push        (rd_push),
      .push_packet (packet_in),
      .pop         (rd_pop),
      .head_packet (rd_head),
      .nonempty    (rd_nonempty),
      .full        (rd_full)
   );

   //############################################################
   // Memory stage
   //############################################################
   emem_core #(
      .MEM_LINES (MEM_LINES)
   ) core0 (
      .clk          (clk),
      .arst_n       (arst_n),
      .wr_valid     (wr_nonempty),
      .wr_packet    (wr_head),
      .rd_valid     (rd_nonempty),
      .rd_packet    (rd_head),
      .stall        (stall),
      .wr_pop       (wr_pop),
      .rd_pop       (rd_pop),
      .rd_req_valid (rd_req_valid),
      .rd_req       (rd_req),
      .rd_data      (rd_data)
   );

   //############################################################
   // Response stage
   //############################################################
   emem_response resp0 (
      .clk          (clk),
      .arst_n       (arst_n),
      .rd_req_valid (rd_req_valid),
      .rd_req       (rd_req),
      .rd_data      (rd_data),
      .wait_in      (wait_in),
      .stall        (stall),
      .access_out   (access_out),
      .packet_out   (packet_out)
   );

endmodule

/* source/emesh_fifo.sv */
`timescale 1ns/1ps

module emesh_fifo #(
   parameter int FIFO_DEPTH = 4
) (
   input  logic                     clk,
   input  logic                     arst_n,
   input  logic                     push,
   input  emesh_pkg::emesh_packet_t push_packet,
   input  logic                     pop,
   output emesh_pkg::emesh_packet_t head_packet,
   output logic                     nonempty,
   output logic                     full
);

   import emesh_pkg::*;

   localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
   localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

   emesh_packet_t    buf_mem [FIFO_DEPTH];    // Packet storage
   logic [PTR_W-1:0] wr_ptr;                  // Next slot to fill
   logic [PTR_W-1:0] rd_ptr;                  // Current head slot
   logic [CNT_W-1:0] count;                   // Occupancy
   logic             do_push;
   logic             do_pop;

   // Wrap at depth, also for non power of two
   function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
      logic [PTR_W-1:0] nxt;
      if (ptr == PTR_W'(FIFO_DEPTH - 1)) begin
         nxt = '0;
      end else begin
         nxt = ptr + 1'b1;
      end
      return nxt;
   endfunction

   assign do_push = push & ~full;             // Push into a full queue is lost
   assign do_pop  = pop & nonempty;           // Pop of an empty queue ignored

   assign nonempty    = (count != '0);
   assign full        = (count == CNT_W'(FIFO_DEPTH));
   assign head_packet = buf_mem[rd_ptr];      // Head offered without a pop

   //############################################################
   // Storage
   //############################################################
   always_ff @(posedge clk) begin
      if (do_push) begin
         buf_mem[wr_ptr] <= push_packet;
      end
   end

   //############################################################
   // Pointers and occupancy
   //############################################################
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (do_push) begin
            wr_ptr <= next_ptr(wr_ptr);
         end
         if (do_pop) begin
            rd_ptr <= next_ptr(rd_ptr);
         end
         case ({do_push, do_pop})
            2'b10:   count <= count + 1'b1;   // Fill only
            2'b01:   count <= count - 1'b1;   // Drain only
            default: count <= count;          // Both or neither
         endcase
      end
   end

endmodule

/* source/emesh_pkg.sv */
package emesh_pkg;

   //############################################################
   // Mesh packet geometry
   //############################################################
   localparam int PW     = 104;          // Full packet width
   localparam int AW     = 32;           // Address width
   localparam int DW     = 32;           // Data word width
   localparam int CW     = 4;            // Ctrlmode width
   localparam int LINE_W = AW - 3;       // Address bits above the 8-byte line offset

   // Access size codes carried in bits 2:1
   typedef enum logic [1:0] {
      dm_byte   = 2'd0,                  // Treated as a word access
      dm_half   = 2'd1,                  // Treated as a word access
      dm_word   = 2'd2,                  // 32-bit half of a line
      dm_double = 2'd3                   // Whole 64-bit line
   } datamode_t;

   //############################################################
   // Two decodes of the same 104-bit word
   //############################################################
   typedef struct packed {
      logic [DW-1:0] data_hi;            // Bits 103:72, upper data
      logic [DW-1:0] data_lo;            // Bits 71:40
      logic [AW-1:0] dstaddr;            // Bits 39:8
      logic          rsvd;               // Bit 7
      logic [CW-1:0] ctrlmode;           // Bits 6:3
      datamode_t     datamode;           // Bits 2:1
      logic          write;              // Bit 0
   } emesh_wr_t;

   typedef struct packed {
      logic [AW-1:0] return_addr;        // Bits 103:72, where the answer goes
      logic [DW-1:0] data_unused;        // Bits 71:40, ignored on reads
      logic [AW-1:0] dstaddr;            // Bits 39:8
      logic          rsvd;               // Bit 7
      logic [CW-1:0] ctrlmode;           // Bits 6:3
      datamode_t     datamode;           // Bits 2:1
      logic          write;              // Bit 0, low for reads
   } emesh_rd_t;

   typedef union packed {
      emesh_wr_t wr_view;                // Write decode
      emesh_rd_t rd_view;                // Read decode
   } emesh_packet_t;

   //############################################################
   // Decoded memory request, core to response stage
   //############################################################
   typedef struct packed {
      logic              write;          // Write or read
      datamode_t         datamode;       // Access size
      logic [CW-1:0]     ctrlmode;       // Echoed in the response
      logic [LINE_W-1:0] line;           // Line index, dstaddr 31:3
      logic              half;           // dstaddr bit 2
      logic [2*DW-1:0]   wdata;          // Line-aligned write data
      logic [AW-1:0]     return_addr;    // Response destination
   } mem_req_t;

endpackage

/* test/emem_assert.sv */
`timescale 1ns/1ps

module emem_assert (
   input logic                     clk,
   input logic                     arst_n,
   input logic                     access_in,
   input logic                     wait_out,
   input logic                     access_out,
   input emesh_pkg::emesh_packet_t packet_out,
   input logic                     wait_in,
   input logic                     wr_store,
   input logic                     rd_store
);

   //############################################################
   // Output side
   //############################################################
   // Response held steady until taken
   a_hold: assert property (@(posedge clk) disable iff (!arst_n)
      (access_out && wait_in) |=> (access_out && $stable(packet_out)))
      else $error("Response changed while wait_in was high");

   // Nothing leaves during reset
   a_reset: assert property (@(posedge clk) !arst_n |-> !access_out)
      else $error("access_out high during reset");

   //############################################################
   // Entry side
   //############################################################
   // Queue storage stays idle while entry is held off
   a_no_accept: assert property (@(posedge clk) disable iff (!arst_n)
      (access_in && wait_out) |-> !(wr_store || rd_store))
      else $error("Packet accepted while wait_out was high");

endmodule

bind emem_top emem_assert assert0 (
   .clk        (clk),
   .arst_n     (arst_n),
   .access_in  (access_in),
   .wait_out   (wait_out),
   .access_out (access_out),
   .packet_out (packet_out),
   .wait_in    (wait_in),
   .wr_store   (wr_fifo.do_push),
   .rd_store   (rd_fifo.do_push)
);

/* test/tb_clock.sv */
`timescale 1ns/1ps

module tb_clock #(
   parameter int PERIOD_NS    = 8,
   parameter int RESET_CYCLES = 8
) (
   output logic clk,
   output logic arst_n
);

   initial begin
      clk = 1'b0;
      forever #(PERIOD_NS / 2) clk = ~clk;   // Free running
   end

   initial begin
      arst_n = 1'b0;                         // Low from time zero
      repeat (RESET_CYCLES) @(posedge clk);
      #1;
      arst_n = 1'b1;                         // Released just after an edge
   end

endmodule

/* test/tb_emem.sv */
`timescale 1ns/1ps

module tb_emem;

   import emesh_pkg::*;

   localparam int PERIOD_NS    = 8;
   localparam int RESET_CYCLES = 8;
   localparam int FIFO_DEPTH   = 4;
   localparam int MEM_LINES    = 256;
   localparam int SEED         = 58552;
   localparam int BURST_LIMIT  = 2 * FIFO_DEPTH + 1;                  // Reads allowed under wait
   localparam int N_PACKETS    = 32 + 16 + 16 + 16 + (BURST_LIMIT + 2) + 24;
   localparam int WATCHDOG_NS  = 20 * N_PACKETS * PERIOD_NS + RESET_CYCLES * PERIOD_NS;

   logic          clk;
   logic          arst_n;
   logic          access_in;
   emesh_packet_t packet_in;
   logic          wait_out;
   logic          access_out;
   emesh_packet_t packet_out;
   logic          wait_in;
   logic          force_wait;                 // Hold wait_in high
   logic          random_en;                  // Random wait_in pulses
   logic          nxt_wait;
   logic [63:0]   model_mem [MEM_LINES];      // Reference memory
   emesh_packet_t exp_q [$];                  // Expected responses in read order
   emesh_packet_t exp_pkt;
   int            errors  = 0;
   int            checked = 0;

   tb_clock #(.PERIOD_NS(PERIOD_NS), .RESET_CYCLES(RESET_CYCLES)) clk0 (
      .clk    (clk),
      .arst_n (arst_n)
   );

   emem_top #(.FIFO_DEPTH(FIFO_DEPTH), .MEM_LINES(MEM_LINES)) dut0 (
      .clk        (clk),
      .arst_n     (arst_n),
      .access_in  (access_in),
      .packet_in  (packet_in),
      .wait_out   (wait_out),
      .access_out (access_out),
      .packet_out (packet_out),
      .wait_in    (wait_in)
   );

   //############################################################
   // Packet builders and reference model
   //############################################################
   function automatic emesh_packet_t make_write(input int line, input logic half,
      input datamode_t dm, input logic [31:0] lo, input logic [31:0] hi, input logic [3:0] ctrl);
      emesh_packet_t p;
      p                  = '0;
      p.wr_view.write    = 1'b1;
      p.wr_view.datamode = dm;
      p.wr_view.ctrlmode = ctrl;
      p.wr_view.dstaddr  = {LINE_W'(line), half, 2'b00};   // 8-byte lines
      p.wr_view.data_lo  = lo;
      p.wr_view.data_hi  = hi;                             // Ignored by word writes
      return p;
   endfunction

   function automatic emesh_packet_t make_read(input int line, input logic half,
      input datamode_t dm, input logic [3:0] ctrl, input logic [31:0] ret);
      emesh_packet_t p;
      p                     = '0;
      p.rd_view.datamode    = dm;
      p.rd_view.ctrlmode    = ctrl;
      p.rd_view.dstaddr     = {LINE_W'(line), half, 2'b00};
      p.rd_view.data_unused = $urandom;                    // Junk, must not matter
      p.rd_view.return_addr = ret;
      return p;
   endfunction

   // Writes update the model, reads return the expected answer
   function automatic emesh_packet_t model_access(input emesh_packet_t pkt);
      emesh_packet_t rsp;
      logic [63:0]   line_val;
      int            idx;
      rsp = '0;
      idx = int'(pkt.wr_view.dstaddr[AW-1:3]) % MEM_LINES;
      if (pkt.wr_view.write) begin
         if (pkt.wr_view.datamode == dm_double) begin
            model_mem[idx] = {pkt.wr_view.data_hi, pkt.wr_view.data_lo};
         end else if (pkt.wr_view.dstaddr[2]) begin
            model_mem[idx][63:32] = pkt.wr_view.data_lo;    // Byte and half act as word
         end else begin
            model_mem[idx][31:0] = pkt.wr_view.data_lo;
         end
      end else begin
         line_val             = model_mem[idx];
         rsp.wr_view.write    = 1'b1;
         rsp.wr_view.datamode = pkt.rd_view.datamode;
         rsp.wr_view.ctrlmode = pkt.rd_view.ctrlmode;
         rsp.wr_view.dstaddr  = pkt.rd_view.return_addr;
         if (pkt.rd_view.datamode == dm_double) begin
            rsp.wr_view.data_lo = line_val[31:0];
            rsp.wr_view.data_hi = line_val[63:32];
         end else begin
            rsp.wr_view.data_lo = pkt.rd_view.dstaddr[2] ? line_val[63:32] : line_val[31:0];
         end
      end
      return rsp;
   endfunction

   //############################################################
   // Checks
   //############################################################
   task automatic check_packet(input emesh_packet_t got, input emesh_packet_t exp,
      input string what);
      if (got !== exp) begin
         errors++;
         $display("Error at %0t ns: %s got %h expected %h", $time, what, got, exp);
      end
   endtask

   task automatic check_flag(input logic got, input logic exp, input string what);
      if (got !== exp) begin
         errors++;
         $display("Error at %0t ns: %s got %b expected %b", $time, what, got, exp);
      end
   endtask

   // Sampled mid-cycle, taken at the next rising edge
   always @(negedge clk) begin
      if (arst_n && access_out && !wait_in) begin
         if (exp_q.size() == 0) begin
            errors++;
            $display("Error at %0t ns: response delivered with no read outstanding", $time);
         end else begin
            exp_pkt = exp_q.pop_front();
            check_packet(packet_out, exp_pkt, "read response");
            checked++;
         end
      end
   end

   //############################################################
   // Stimulus
   //############################################################
   task automatic send_packet(input emesh_packet_t pkt);
      logic taken;
      access_in = 1'b1;
      packet_in = pkt;
      taken     = 1'b0;
      while (!taken) begin
         @(negedge clk);
         taken = !wait_out;                    // Stable until the edge
         @(posedge clk);
         #1;
      end
      access_in = 1'b0;
      if (!pkt.wr_view.write) begin
         exp_q.push_back(model_access(pkt));
      end else begin
         void'(model_access(pkt));
      end
   endtask

   task automatic wait_drained();
      while (exp_q.size() != 0) begin
         @(posedge clk);
      end
      repeat (2) @(posedge clk);
      #1;
   endtask

   // wait_in driver, decided at the edge, applied 1 ns later
   initial begin
      wait_in = 1'b0;
      forever begin
         @(posedge clk);
         nxt_wait = force_wait | (random_en & ($urandom_range(2, 0) == 0));
         #1;
         wait_in = nxt_wait;
      end
   end

   initial begin
      int            lines [16];
      logic          halves [16];
      int            accepted;
      logic          wait_seen;
      emesh_packet_t pkt;
      void'($urandom(SEED));
      access_in  = 1'b0;
      packet_in  = '0;
      force_wait = 1'b0;
      random_en  = 1'b0;
      @(posedge arst_n);
      @(posedge clk);
      #1;
      // Word writes, word reads back
      for (int i = 0; i < 16; i++) begin
         lines[i]  = 64 + int'($urandom_range(63, 0));
         halves[i] = 1'($urandom_range(1, 0));
         send_packet(make_write(lines[i], halves[i], dm_word, $urandom, $urandom, 4'($urandom)));
      end
      for (int i = 0; i < 16; i++) begin
         send_packet(make_read(lines[i], halves[i], dm_word, 4'($urandom), $urandom));
      end
      wait_drained();
      // Double writes, double reads
      for (int i = 0; i < 8; i++) begin
         send_packet(make_write(i, 1'($urandom), dm_double, $urandom, $urandom, 4'($urandom)));
      end
      for (int i = 0; i < 8; i++) begin
         send_packet(make_read(i, 1'($urandom), dm_double, 4'($urandom), $urandom));
      end
      wait_drained();
      // Word write over a full line, other half kept
      for (int i = 0; i < 8; i++) begin
         send_packet(make_write(i, 1'($urandom), dm_word, $urandom, $urandom, 4'($urandom)));
         send_packet(make_read(i, 1'($urandom), dm_double, 4'($urandom), $urandom));
      end
      wait_drained();
      // Random back-pressure
      random_en = 1'b1;
      for (int i = 0; i < 16; i++) begin
         send_packet(make_read(int'($urandom_range(7, 0)), 1'($urandom),
            datamode_t'(2'($urandom)), 4'($urandom), $urandom));
      end
      wait_drained();
      random_en = 1'b0;
      // Read burst under held wait_in
      force_wait = 1'b1;
      @(posedge clk);
      #1;
      accepted  = 0;
      wait_seen = 1'b0;
      while (!wait_seen && accepted <= BURST_LIMIT) begin
         pkt       = make_read(int'($urandom_range(7, 0)), 1'($urandom),
            datamode_t'(2'($urandom)), 4'($urandom), $urandom);
         access_in = 1'b1;
         packet_in = pkt;
         @(negedge clk);
         wait_seen = wait_out;
         @(posedge clk);
         if (!wait_seen) begin
            exp_q.push_back(model_access(pkt));
            accepted++;
         end
         #1;
      end
      access_in = 1'b0;
      check_flag(wait_seen, 1'b1, "wait_out during held read burst");
      force_wait = 1'b0;
      wait_drained();
      // Mixed traffic, writes above line 127, reads of lines 0 to 7
      for (int i = 0; i < 24; i++) begin
         if ($urandom_range(1, 0) == 1) begin
            send_packet(make_write(128 + int'($urandom_range(63, 0)), 1'($urandom),
               datamode_t'(2'($urandom)), $urandom, $urandom, 4'($urandom)));
         end else begin
            send_packet(make_read(int'($urandom_range(7, 0)), 1'($urandom),
               datamode_t'(2'($urandom)), 4'($urandom), $urandom));
         end
      end
      wait_drained();
      $display("Closing: %0d errors, %0d responses checked", errors, checked);
      if (errors == 0) begin
         $display("ALL CHECKS PASSED");
      end else begin
         $display("CHECKS FAILED");
      end
      $finish;
   end

   // Watchdog
   initial begin
      #(WATCHDOG_NS);
      $display("Timeout: responses still outstanding after %0d ns", WATCHDOG_NS);
      $display("CHECKS FAILED");
      $finish;
   end

endmodule
